// File: verilog.f
+incdir+hw
hw/cmd_pkg.sv
hw/sync_pkg.sv
hw/cmd_deser.sv
hw/sync_regs.sv
hw/frame_gate.sv
hw/late_sof.sv
hw/sens_sync.sv
tb/tb_sens_sync.sv

// File: Bender.yml
package:
  name: sens_sync

sources:
  - include_dirs:
      - hw
    files:
      - hw/cmd_pkg.sv
      - hw/sync_pkg.sv
      - hw/cmd_deser.sv
      - hw/sync_regs.sv
      - hw/frame_gate.sv
      - hw/late_sof.sv
      - hw/sens_sync.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/tb_sens_sync.sv

// File: tb/tb_sens_sync.sv
// directed testbench of the frame sync channel with command driver, pulse drivers and compare tasks
`timescale 1ns/1ps
`default_nettype none

`include "sync_params.svh"

module tb_sens_sync;
    import cmd_pkg::*;

    logic       mclk;
    logic       rst;
    logic [7:0] cmd_ad;
    logic       cmd_stb;
    logic       en;
    logic       sof_in;
    logic       eof_in;
    logic       hact;
    logic       trigger_mode;
    logic       trig_in;
    logic       trig;
    logic       sof_out;
    logic       sof_late;

    int         errors = 0;
    int         n_sof  = 0;         // sof_out pulses seen so far
    int         n_late = 0;         // sof_late pulses seen so far
    integer     seed   = 19406;

    localparam cmd_addr_t MULT_ADDR = (`SYNC_ADDR & `SYNC_MASK) | 16'(REG_MULT);
    localparam cmd_addr_t LATE_ADDR = (`SYNC_ADDR & `SYNC_MASK) | 16'(REG_LATE);

    sens_sync i_sens_sync (
        .mclk         (mclk),
        .rst          (rst),
        .cmd_ad       (cmd_ad),
        .cmd_stb      (cmd_stb),
        .en           (en),
        .sof_in       (sof_in),
        .eof_in       (eof_in),
        .hact         (hact),
        .trigger_mode (trigger_mode),
        .trig_in      (trig_in),
        .trig         (trig),
        .sof_out      (sof_out),
        .sof_late     (sof_late)
    );

    initial begin
        mclk = 1'b0;
        forever #2 mclk = ~mclk;    // 4 ns period
    end

    always @(negedge mclk) begin
        if (!rst && sof_out) n_sof++;
        if (!rst && sof_late) n_late++;
    end

    task automatic check_pulse(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s: expected %0b, actual %0b", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            errors++;
            $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // idle gap comfortably above the minimum frame period
    function automatic int rand_gap();
        return `SYNC_MINPER + 12 + ($random(seed) & 63);
    endfunction

    task automatic idle(input int n);
        repeat (n) @(posedge mclk);
    endtask

    // six bytes al, ah, d0..d3, then count the write strobes
    task automatic send_cmd(input cmd_addr_t addr, input cmd_data_t data,
                            input int exp_we, input string name);
        int seen;
        seen = 0;
        @(posedge mclk);
        cmd_stb <= 1'b1;
        cmd_ad  <= addr[7:0];
        @(posedge mclk);
        cmd_stb <= 1'b0;
        cmd_ad  <= addr[15:8];
        for (int i = 0; i < 4; i++) begin
            @(posedge mclk);
            cmd_ad <= data[8*i +: 8];
        end
        @(posedge mclk);
        cmd_ad <= 8'h00;
        for (int k = 0; k < 4; k++) begin
            @(negedge mclk);
            if (i_sens_sync.reg_we) seen++;
        end
        @(posedge mclk);                                    // register now updated
        check_count(name, exp_we, seen);
    endtask

    // sof_out must follow one cycle after sof_in, or not at all
    task automatic frame_start(input int gap, input logic exp, input string name);
        idle(gap);
        sof_in <= 1'b1;
        @(posedge mclk);
        sof_in <= 1'b0;
        @(negedge mclk);
        check_pulse(name, exp, sof_out);
    endtask

    task automatic line_pulses(input int n);
        repeat (n) begin
            @(posedge mclk);
            hact <= 1'b1;
            idle(3);
            hact <= 1'b0;
            idle(3);
        end
    endtask

    task automatic end_frame();
        @(posedge mclk);
        eof_in <= 1'b1;
        @(posedge mclk);
        eof_in <= 1'b0;
    endtask

    task automatic request_trigger();
        @(posedge mclk);
        trig_in <= 1'b1;
        @(posedge mclk);
        trig_in <= 1'b0;
        @(negedge mclk);
    endtask

    task automatic wait_late(input string name, input int limit);
        logic seen;
        seen = 1'b0;
        for (int k = 0; k < limit && !seen; k++) begin
            @(negedge mclk);
            if (sof_late) seen = 1'b1;
        end
        if (!seen) begin
            errors++;
            $display("%s: sof_late did not arrive within %0d cycles", name, limit);
        end
    endtask

    // en low for one cycle clears sub-frame, period and late state
    task automatic clear_gate();
        @(posedge mclk);
        en <= 1'b0;
        @(posedge mclk);
        en <= 1'b1;
    endtask

    task automatic free_run_frames();
        int base;
        int base_late;
        base      = n_sof;
        base_late = n_late;
        for (int i = 0; i < 4; i++) frame_start(rand_gap(), 1'b1, "free_run");
        idle(4);
        check_count("free_run count", 4, n_sof - base);
        line_pulses(`SYNC_LATE_DFLT);                       // default delay, still armed
        check_count("default late early", 0, n_late - base_late);
        line_pulses(1);                                     // next edge fires
        check_count("default late", 1, n_late - base_late);
    endtask

    task automatic combine_frames(input int n);
        int base;
        send_cmd(MULT_ADDR, cmd_data_t'(n), 1, "mult write");
        clear_gate();
        base = n_sof;
        for (int i = 0; i < 8; i++) frame_start(rand_gap(), (i % (n + 1)) == 0, "mult");
        idle(4);
        check_count("mult count", (7 / (n + 1)) + 1, n_sof - base);
        send_cmd(MULT_ADDR, '0, 1, "mult restore");
        clear_gate();
    endtask

    task automatic late_sync_lines(input int l_long, input int l_short);
        int base;
        base = n_late;
        send_cmd(LATE_ADDR, cmd_data_t'(l_long), 1, "late write");
        frame_start(rand_gap(), 1'b1, "late frame");
        line_pulses(l_long);                                // l edges, still armed
        check_count("late early", 0, n_late - base);
        @(posedge mclk);
        hact <= 1'b1;                                       // edge l+1 fires
        wait_late("late lines", 6);
        @(posedge mclk);
        hact <= 1'b0;
        send_cmd(LATE_ADDR, cmd_data_t'(l_short), 1, "late write 2");
        frame_start(rand_gap(), 1'b1, "eof frame");
        line_pulses(2);                                     // well short of l_short
        end_frame();
        wait_late("late eof", 2);
        idle(4);
        check_count("late count", 2, n_late - base);
    endtask

    task automatic min_period_filter();
        frame_start(rand_gap(), 1'b1, "period first");
        frame_start(50, 1'b0, "period short");              // inside the blocked window
        frame_start(rand_gap(), 1'b1, "period after");
    endtask

    task automatic trigger_frames();
        @(posedge mclk);
        trigger_mode <= 1'b1;
        clear_gate();
        frame_start(rand_gap(), 1'b1, "trig first");
        frame_start(rand_gap(), 1'b0, "trig none");
        request_trigger();
        check_pulse("trig set", 1'b1, trig);
        frame_start(rand_gap(), 1'b1, "trig accept");
        check_pulse("trig clear", 1'b0, trig);
        request_trigger();
        request_trigger();                                  // second one marks overdue
        frame_start(rand_gap(), 1'b1, "trig overdue");
        check_pulse("trig clear 2", 1'b0, trig);
        @(posedge mclk);
        trigger_mode <= 1'b0;
        clear_gate();
    endtask

    task automatic disable_channel();
        int base_sof;
        int base_late;
        base_sof  = n_sof;
        base_late = n_late;
        @(posedge mclk);
        en <= 1'b0;
        frame_start(rand_gap(), 1'b0, "disabled");
        line_pulses(20);
        end_frame();
        idle(4);
        check_count("disabled sof_out", 0, n_sof - base_sof);
        check_count("disabled sof_late", 0, n_late - base_late);
        en <= 1'b1;
        send_cmd(MULT_ADDR ^ 16'h0010, 32'd3, 0, "foreign write");  // other block
        for (int i = 0; i < 3; i++) frame_start(rand_gap(), 1'b1, "foreign");
    endtask

    initial begin
        rst          = 1'b1;
        cmd_ad       = 8'h00;
        cmd_stb      = 1'b0;
        en           = 1'b0;
        sof_in       = 1'b0;
        eof_in       = 1'b0;
        hact         = 1'b0;
        trigger_mode = 1'b0;
        trig_in      = 1'b0;
        repeat (16) @(posedge mclk);
        rst <= 1'b0;
        en  <= 1'b1;
        @(negedge mclk);
        check_pulse("reset sof_out", 1'b0, sof_out);
        check_pulse("reset sof_late", 1'b0, sof_late);
        check_pulse("reset trig", 1'b0, trig);
        check_pulse("reset reg_we", 1'b0, i_sens_sync.reg_we);
        free_run_frames();
        combine_frames(2);
        late_sync_lines(3, 10);
        min_period_filter();
        trigger_frames();
        disable_channel();
        idle(4);
        $display("checks done, errors %0d", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/sens_sync.sv
// sens_sync: top of the frame sync channel, command path and sync pipeline
`timescale 1ns/1ps
`default_nettype none

module sens_sync (
    input  wire        mclk,
    input  wire        rst,
    input  wire [7:0]  cmd_ad,        // byte-serial command
    input  wire        cmd_stb,       // with first byte
    input  wire        en,            // channel enable
    input  wire        sof_in,        // sensor frame start
    input  wire        eof_in,        // sensor frame end
    input  wire        hact,          // sensor line active
    input  wire        trigger_mode,  // 1 triggered
    input  wire        trig_in,       // trigger request
    output logic       trig,          // trigger level to sensor
    output logic       sof_out,       // immediate frame sync
    output logic       sof_late       // delayed frame sync
);
    import cmd_pkg::*;
    import sync_pkg::*;

    logic       reg_we;
    sync_reg_e  reg_sel;
    cmd_data_t  reg_data;
    frame_cnt_t mult;
    line_cnt_t  late_dly;

    cmd_deser i_cmd_deser (
        .mclk     (mclk),
        .rst      (rst),
        .cmd_ad   (cmd_ad),
        .cmd_stb  (cmd_stb),
        .reg_we   (reg_we),
        .reg_sel  (reg_sel),
        .reg_data (reg_data)
    );

    sync_regs i_sync_regs (
        .mclk     (mclk),
        .rst      (rst),
        .reg_we   (reg_we),
        .reg_sel  (reg_sel),
        .reg_data (reg_data),
        .mult     (mult),
        .late_dly (late_dly)
    );

    frame_gate i_frame_gate (
        .mclk         (mclk),
        .rst          (rst),
        .en           (en),
        .sof_in       (sof_in),
        .trigger_mode (trigger_mode),
        .trig_in      (trig_in),
        .mult         (mult),
        .frame_go     (sof_out),      // also arms the late sync
        .trig         (trig)
    );

    late_sof i_late_sof (
        .mclk     (mclk),
        .rst      (rst),
        .en       (en),
        .frame_go (sof_out),
        .eof_in   (eof_in),
        .hact     (hact),
        .late_dly (late_dly),
        .sof_late (sof_late)
    );

endmodule

`default_nettype wire

// File: hw/late_sof.sv
// late_sof: line-delayed frame sync, cut short by end of frame
`timescale 1ns/1ps
`default_nettype none

module late_sof (
    input  wire                       mclk,
    input  wire                       rst,
    input  wire                       en,          // low disarms
    input  wire                       frame_go,    // accepted frame start
    input  wire                       eof_in,      // single-cycle end of frame
    input  wire                       hact,        // line active from sensor
    input  wire sync_pkg::line_cnt_t  late_dly,
    output logic                      sof_late     // single-cycle delayed sync
);
    import sync_pkg::*;

    line_cnt_t lines_left;
    logic      armed;            // between frame_go and sof_late
    logic      hact_r;
    logic      hact_rise;
    logic      last_line;
    logic      fire;

    assign hact_rise = hact && !hact_r;
    assign last_line = (lines_left == '0);
    assign fire      = armed && (eof_in || (hact_rise && last_line));

    always_ff @(posedge mclk) begin
        if (rst) begin
            hact_r <= 1'b0;
        end else begin
            hact_r <= hact;                              // edge detect
        end
    end

    always_ff @(posedge mclk) begin
        if (rst || !en) begin
            armed      <= 1'b0;
            lines_left <= '0;
        end else if (frame_go) begin
            armed      <= 1'b1;
            lines_left <= late_dly;                      // counted in hact edges
        end else if (fire) begin
            armed      <= 1'b0;
        end else if (armed && hact_rise) begin
            lines_left <= lines_left - line_cnt_t'(1);   // never wraps, fires at zero
        end
    end

    always_ff @(posedge mclk) begin
        if (rst) begin
            sof_late <= 1'b0;
        end else begin
            sof_late <= fire;
        end
    end

endmodule

`default_nettype wire

// File: hw/frame_gate.sv
// frame_gate: sub-frame combining, sensor trigger and minimum period filter on sof_in
`timescale 1ns/1ps
`default_nettype none

`include "sync_params.svh"

module frame_gate (
    input  wire                        mclk,
    input  wire                        rst,
    input  wire                        en,            // low clears the gate
    input  wire                        sof_in,        // single-cycle frame start
    input  wire                        trigger_mode,  // 1 triggered, 0 free running
    input  wire                        trig_in,       // single-cycle trigger request
    input  wire sync_pkg::frame_cnt_t  mult,
    output logic                       frame_go,      // accepted frame start, one cycle late
    output logic                       trig           // to sensor, pending until frame start
);
    import sync_pkg::*;

    frame_cnt_t  sub_left;       // sub-frames until next accepted start
    period_cnt_t period_cnt;     // cycles left of the minimum period
    logic        free_en;        // first frame after entering triggered mode
    logic        overdue;        // trigger came again before the frame
    logic        sub_zero;
    logic        period_busy;
    logic        pre_go;

    assign sub_zero    = (sub_left == '0);
    assign period_busy = (period_cnt != '0);
    assign pre_go      = en && sof_in && sub_zero && !period_busy &&
                         (free_en || trig || overdue);

    // linescan sub-frame counter
    always_ff @(posedge mclk) begin
        if (rst || !en) begin
            sub_left <= '0;                          // next start is eligible
        end else if (sof_in) begin
            if (sub_zero) begin
                sub_left <= mult;                    // new combined frame
            end else begin
                sub_left <= sub_left - frame_cnt_t'(1);
            end
        end
    end

    // minimum period, counts from each accepted start
    always_ff @(posedge mclk) begin
        if (rst || !en) begin
            period_cnt <= '0;
        end else if (pre_go) begin
            period_cnt <= period_cnt_t'(`SYNC_MINPER);
        end else if (period_busy) begin
            period_cnt <= period_cnt - period_cnt_t'(1);
        end
    end

    // free-run allowance, held while not triggered
    always_ff @(posedge mclk) begin
        if (rst || !en || !trigger_mode) begin
            free_en <= 1'b1;
        end else if (pre_go) begin
            free_en <= 1'b0;                         // from now on wait for trig
        end
    end

    // trigger pending to the sensor
    always_ff @(posedge mclk) begin
        if (rst || !en || !trigger_mode) begin
            trig <= 1'b0;
        end else if (trig_in) begin
            trig <= 1'b1;                            // new request wins over accept
        end else if (pre_go) begin
            trig <= 1'b0;
        end
    end

    // second trigger before the frame, avoids lock-up at long exposure
    always_ff @(posedge mclk) begin
        if (rst || !en || !trigger_mode || pre_go) begin
            overdue <= 1'b0;
        end else if (trig_in && trig) begin
            overdue <= 1'b1;
        end
    end

    always_ff @(posedge mclk) begin
        if (rst) begin
            frame_go <= 1'b0;
        end else begin
            frame_go <= pre_go;                      // one cycle after sof_in
        end
    end

endmodule

`default_nettype wire

// File: hw/sync_regs.sv
// sync_regs: frame multiplier and late sync line delay registers
`timescale 1ns/1ps
`default_nettype none

`include "sync_params.svh"

module sync_regs (
    input  wire                          mclk,
    input  wire                          rst,
    input  wire                          reg_we,     // decoded write pulse
    input  wire cmd_pkg::sync_reg_e      reg_sel,
    input  wire cmd_pkg::cmd_data_t      reg_data,
    output sync_pkg::frame_cnt_t         mult,       // frames combined, minus one
    output sync_pkg::line_cnt_t          late_dly    // lines to sof_late
);
    import cmd_pkg::*;
    import sync_pkg::*;

    always_ff @(posedge mclk) begin
        if (rst) begin
            mult     <= '0;                                  // every frame passes
            late_dly <= line_cnt_t'(`SYNC_LATE_DFLT);
        end else if (reg_we) begin
            case (reg_sel)
                REG_MULT: mult     <= reg_data[$bits(frame_cnt_t)-1:0]; // upper bits dropped
                REG_LATE: late_dly <= reg_data[$bits(line_cnt_t)-1:0];
                default: begin
                    // reserved, never strobed by cmd_deser
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/cmd_deser.sv
// cmd_deser: byte-serial command assembly and register write decode
`timescale 1ns/1ps
`default_nettype none

`include "sync_params.svh"

module cmd_deser (
    input  wire                  mclk,
    input  wire                  rst,
    input  wire [7:0]            cmd_ad,     // al, ah, d0, d1, d2, d3
    input  wire                  cmd_stb,    // with al only
    output logic                 reg_we,     // one cycle after d3
    output cmd_pkg::sync_reg_e   reg_sel,
    output cmd_pkg::cmd_data_t   reg_data
);
    import cmd_pkg::*;

    localparam int CNT_W = $clog2(`CMD_BYTES);

    logic [CNT_W-1:0] byte_cnt;                     // 0 when idle, else index of this byte
    cmd_addr_t        addr_r;                       // al first, ends up in low byte
    cmd_data_t        data_r;                       // d0 first, ends up in low byte
    logic             last_byte;
    logic             addr_hit;
    logic             sel_ok;

    assign last_byte = (byte_cnt == CNT_W'(`CMD_BYTES - 1));
    assign addr_hit  = ((addr_r & `SYNC_MASK) == (`SYNC_ADDR & `SYNC_MASK));
    assign sel_ok    = (addr_r[1:0] == REG_MULT) || (addr_r[1:0] == REG_LATE);

    // byte position, restarts on every strobe
    always_ff @(posedge mclk) begin
        if (rst) begin
            byte_cnt <= '0;
        end else if (cmd_stb) begin
            byte_cnt <= CNT_W'(1);                  // next byte is ah
        end else if (byte_cnt != '0) begin
            if (last_byte) begin
                byte_cnt <= '0;                     // command done
            end else begin
                byte_cnt <= byte_cnt + CNT_W'(1);
            end
        end
    end

    // address and data shift registers
    always_ff @(posedge mclk) begin
        if (cmd_stb || (byte_cnt == CNT_W'(1))) begin
            addr_r <= {cmd_ad, addr_r[15:8]};       // al then ah
        end
        if (!cmd_stb && (byte_cnt >= CNT_W'(2))) begin
            data_r <= {cmd_ad, data_r[31:8]};       // d0..d3, lsb first
        end
    end

    // write strobe lines up with the completed data word
    always_ff @(posedge mclk) begin
        if (rst) begin
            reg_we <= 1'b0;
        end else begin
            reg_we <= !cmd_stb && last_byte && addr_hit && sel_ok;
        end
    end

    assign reg_sel  = sync_reg_e'(addr_r[1:0]);     // stable until next command
    assign reg_data = data_r;

endmodule

`default_nettype wire

// File: hw/sync_pkg.sv
// counter types of the frame sync pipeline
`default_nettype none

package sync_pkg;

    `include "sync_params.svh"

    // multiplier and sub-frames left
    typedef logic [`SYNC_FBITS-1:0]   frame_cnt_t;

    // line delay and lines left
    typedef logic [`SYNC_LBITS-1:0]   line_cnt_t;

    // minimum period timer
    typedef logic [`SYNC_MINBITS-1:0] period_cnt_t;

endpackage

`default_nettype wire

// File: hw/cmd_pkg.sv
// command address and data types, register select encoding
`default_nettype none

package cmd_pkg;

    typedef logic [15:0] cmd_addr_t;    // full command address, al + ah
    typedef logic [31:0] cmd_data_t;    // d0..d3, d0 in the low byte

    // low two address bits inside the block
    typedef enum logic [1:0] {
        REG_RSVD0 = 2'd0,               // kept free for control
        REG_RSVD1 = 2'd1,               // kept free for status
        REG_MULT  = 2'd2,               // frames to combine, minus one
        REG_LATE  = 2'd3                // line delay of sof_late
    } sync_reg_e;

endpackage

`default_nettype wire

// File: hw/sync_params.svh
// address match, counter widths, register defaults and minimum frame period for the sync block
`ifndef SYNC_PARAMS_SVH
`define SYNC_PARAMS_SVH

// command decode
`define SYNC_ADDR      16'h0404     // base address of the sync block
`define SYNC_MASK      16'hfffc     // low two bits select the register
`define CMD_BYTES      6            // al, ah, d0..d3

// linescan sub-frame combining
`define SYNC_FBITS     16           // sub-frame counter width

// late frame sync
`define SYNC_LBITS     16           // line delay counter width
`define SYNC_LATE_DFLT 15           // lines after sof_out, by default

// minimum frame period
`define SYNC_MINBITS   8            // period counter width
`define SYNC_MINPER    130          // in mclk cycles

`endif
